// File: sdram_ctrl.f
+incdir+rtl
rtl/sdram_ctrl_pkg.sv
rtl/sdram_req_if.sv
rtl/sdram_host_port.sv
rtl/sdram_req_fifo.sv
rtl/sdram_cmd_seq.sv
rtl/sdram_ctrl_top.sv
dv/sdram_ctrl_chk.sv
dv/sdram_model.sv
dv/sdram_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the SDRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sdram_ctrl.f \
  --top-module sdram_ctrl_tb --Mdir obj_dir -o sim_bin
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/sim_bin +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: dv/sdram_ctrl_tb.sv
// Testbench top with clock, reset, host stimulus, reference read model, compare process and watchdog
`timescale 1ns/1ps
`include "sdram_ctrl_config.svh"

module sdram_ctrl_tb
  import sdram_ctrl_pkg::*;
();

  localparam int CLK_PERIOD  = 40;
  localparam int N_RANDOM    = 40;
  localparam int N_LONG      = 300;
  // Directed, random burst, address split and long run requests
  localparam int N_REQ       = 3 + N_RANDOM + 8 + N_LONG;
  localparam int WATCHDOG_NS = (N_REQ * 40 + `SDRAM_INIT_CYCLES + 100) * CLK_PERIOD;
  localparam int REF_GAP_MAX = `SDRAM_REFRESH_INTERVAL + 20;
  localparam int MIN_CYCLES  = 2000;

  logic        fpga_clk;
  logic        fpga_reset;
  logic        host_req;
  logic        host_ready;
  logic        host_write;
  host_addr_t  host_addr;
  data_t       host_wdata;
  logic        host_rd_valid;
  data_t       host_rd_data;
  sdram_addr_t ram_addr;
  bank_t       ram_bank_addr;
  logic        ram_cs_n;
  logic        ram_ras_n;
  logic        ram_cas_n;
  logic        ram_we_n;
  logic        ram_clk_en;
  wire data_t  ram_data;
  logic        order_err;
  logic        init_err;
  logic        init_done;
  logic        refresh_seen;

  logic [31:0] lfsr = 32'hdd9b_900a;
  // Last written word per host address
  data_t       shadow [host_addr_t];
  // Expected read words in acceptance order
  data_t       exp_q [$];
  int          value_errs = 0;
  int          proto_errs = 0;
  int          cycle_cnt = 0;
  int          last_ref = 0;
  logic        saw_backpressure = 1'b0;

  sdram_ctrl_top sdram_ctrl_top_i (
    .fpga_clk      (fpga_clk),
    .fpga_reset    (fpga_reset),
    .host_req      (host_req),
    .host_ready    (host_ready),
    .host_write    (host_write),
    .host_addr     (host_addr),
    .host_wdata    (host_wdata),
    .host_rd_valid (host_rd_valid),
    .host_rd_data  (host_rd_data),
    .ram_addr      (ram_addr),
    .ram_bank_addr (ram_bank_addr),
    .ram_cs_n      (ram_cs_n),
    .ram_ras_n     (ram_ras_n),
    .ram_cas_n     (ram_cas_n),
    .ram_we_n      (ram_we_n),
    .ram_clk_en    (ram_clk_en),
    .ram_data      (ram_data)
  );

  sdram_model sdram_model_i (
    .fpga_clk      (fpga_clk),
    .ram_addr      (ram_addr),
    .ram_bank_addr (ram_bank_addr),
    .ram_cs_n      (ram_cs_n),
    .ram_ras_n     (ram_ras_n),
    .ram_cas_n     (ram_cas_n),
    .ram_we_n      (ram_we_n),
    .ram_clk_en    (ram_clk_en),
    .ram_data      (ram_data),
    .order_err     (order_err),
    .init_err      (init_err),
    .init_done     (init_done),
    .refresh_seen  (refresh_seen)
  );

  bind sdram_cmd_seq sdram_ctrl_chk sdram_ctrl_chk_i (
    .fpga_clk   (fpga_clk),
    .fpga_reset (fpga_reset),
    .ram_cs_n   (ram_cs_n),
    .ram_ras_n  (ram_ras_n),
    .ram_cas_n  (ram_cas_n),
    .ram_we_n   (ram_we_n),
    .ram_clk_en (ram_clk_en),
    .data_oe    (data_oe)
  );

  initial fpga_clk = 1'b0;
  always #(CLK_PERIOD / 2) fpga_clk = ~fpga_clk;

  // Galois form, taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Small address set so reads often hit earlier writes
  function automatic host_addr_t rand_addr();
    logic [31:0] b;
    b = rand_bits(8);
    return {b[7:6], 9'd0, b[5:3], 6'd0, b[2:0]};
  endfunction

  // Last write wins, unwritten words read back as their own address
  function automatic data_t expect_word(host_addr_t addr);
    if (shadow.exists(addr)) return shadow[addr];
    return data_t'(addr);
  endfunction

  task automatic check_value(input string what, input data_t got, input data_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    proto_errs++;
    $display("Protocol error at %0t ns: %s", $time, msg);
  endtask

  task automatic step();
    @(posedge fpga_clk);
    #2;
  endtask

  // Called 2 ns after an edge, returns 2 ns after the accepting edge
  task automatic send_req(input logic write, input host_addr_t addr, input data_t wdata);
    host_req   = 1'b1;
    host_write = write;
    host_addr  = addr;
    host_wdata = wdata;
    #1;
    // host_ready comes from registers and is stable here
    while (!host_ready) begin
      saw_backpressure = 1'b1;
      @(posedge fpga_clk);
      #3;
    end
    if (write) shadow[addr] = wdata;
    else exp_q.push_back(expect_word(addr));
    step();
  endtask

  task automatic random_req();
    logic [31:0] w;
    host_addr_t  a;
    logic [31:0] d;
    w = rand_bits(1);
    a = rand_addr();
    d = rand_bits(32);
    send_req(w[0], a, d);
  endtask

  task automatic idle(input int n);
    host_req = 1'b0;
    repeat (n) step();
  endtask

  task automatic wait_reads();
    while (exp_q.size() != 0) step();
  endtask

  // Compare and pin watch at mid cycle
  always @(negedge fpga_clk) begin
    if (!fpga_reset) begin
      cycle_cnt++;
      if (host_rd_valid) begin
        if (exp_q.size() == 0) report_failure("read data returned with no read outstanding");
        else check_value("read data", host_rd_data, exp_q.pop_front());
      end
      if (order_err) report_failure("SDRAM model saw a command in the wrong order");
      if (init_err) report_failure("power-up command sequence was wrong");
      if (refresh_seen) begin
        if (cycle_cnt - last_ref > REF_GAP_MAX) report_failure("refresh gap too long");
        last_ref = cycle_cnt;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with %0d reads outstanding", WATCHDOG_NS,
             exp_q.size());
    $display("sim failed");
    $finish;
  end

  initial begin
    host_addr_t split_addr [4];
    logic [31:0] gap;
    int chk_fails;
    fpga_reset = 1'b1;
    host_req   = 1'b0;
    host_write = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    repeat (2) @(posedge fpga_clk);
    #2;
    fpga_reset = 1'b0;

    // Write then read back, queued while power-up runs
    send_req(1'b1, 23'h12_3456, 32'h5a5a_c3c3);
    send_req(1'b0, 23'h12_3456, '0);
    send_req(1'b0, 23'h7f_ffff, '0);
    idle(1);
    wait_reads();

    // Back-to-back random traffic fills the queue
    saw_backpressure = 1'b0;
    repeat (N_RANDOM) random_req();
    idle(1);
    wait_reads();
    if (!saw_backpressure) report_failure("host_ready never dropped under back-to-back requests");

    // Neighbours in bank, row and column
    split_addr[0] = {2'd1, 12'h0a5, 9'h05a};
    split_addr[1] = split_addr[0] ^ {2'b10, 12'h000, 9'h000};
    split_addr[2] = split_addr[0] ^ {2'b00, 12'h800, 9'h000};
    split_addr[3] = split_addr[0] ^ {2'b00, 12'h000, 9'h100};
    for (int i = 0; i < 4; i++) send_req(1'b1, split_addr[i], 32'hc0de_0000 + i);
    for (int i = 0; i < 4; i++) send_req(1'b0, split_addr[i], '0);
    idle(1);
    wait_reads();

    // Long run with random idle gaps, refresh keeps interleaving
    repeat (N_LONG) begin
      random_req();
      gap = rand_bits(2);
      if (gap[1]) idle(int'(gap[0]) + 1);
    end
    while (cycle_cnt < MIN_CYCLES) random_req();
    idle(1);
    wait_reads();
    idle(4);

    if (cycle_cnt - last_ref > REF_GAP_MAX) report_failure("refresh stopped before the end");
    if (!init_done) report_failure("power-up sequence never completed");
    chk_fails = sdram_ctrl_top_i.sdram_cmd_seq_i.sdram_ctrl_chk_i.fail_cnt;
    $display("Value errors %0d, protocol errors %0d, assertion failures %0d",
             value_errs, proto_errs, chk_fails);
    if (value_errs + proto_errs + chk_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: dv/sdram_model.sv
// Behavioral SDRAM with command decode, word storage, CAS latency read return and order flags
`timescale 1ns/1ps
`include "sdram_ctrl_config.svh"

module sdram_model
  import sdram_ctrl_pkg::*;
(
  input  logic        fpga_clk,
  input  sdram_addr_t ram_addr,
  input  bank_t       ram_bank_addr,
  input  logic        ram_cs_n,
  input  logic        ram_ras_n,
  input  logic        ram_cas_n,
  input  logic        ram_we_n,
  input  logic        ram_clk_en,
  inout  data_t       ram_data,
  output logic        order_err,
  output logic        init_err,
  output logic        init_done,
  output logic        refresh_seen
);

  localparam int NBANK = 1 << `SDRAM_BANK_W;

  // Mode register with single location writes at bit 9 and CAS latency at bits 6 to 4
  // Burst length 1 and sequential type encode as zero
  localparam sdram_addr_t MODE_EXPECT =
    sdram_addr_t'((1 << 9) | (`SDRAM_CAS_LATENCY << 4));

  sdram_cmd_t       cmd;
  host_addr_t       loc;
  logic [NBANK-1:0] open_bank = '0;
  row_t             open_row [NBANK];
  // 0 wait precharge, 1 and 2 refreshes, 3 mode load, 4 ready
  int               init_phase = 0;
  data_t            mem [host_addr_t];
  data_t            rd_word = '0;
  int               rd_cnt = 0;

  assign cmd       = sdram_cmd_t'({ram_cs_n, ram_ras_n, ram_cas_n, ram_we_n});
  assign loc       = {ram_bank_addr, open_row[ram_bank_addr], col_t'(ram_addr)};
  assign init_done = (init_phase == 4);
  // Word is on the pins for the cycle that ends at the capture edge
  assign ram_data  = (rd_cnt == 1) ? rd_word : {`SDRAM_DATA_W{1'bz}};

  always @(posedge fpga_clk) begin
    order_err    <= 1'b0;
    init_err     <= 1'b0;
    refresh_seen <= 1'b0;
    if (rd_cnt != 0) rd_cnt <= rd_cnt - 1;
    if (ram_clk_en) begin
      case (cmd)
        CMD_PRECHARGE: begin
          if (init_phase == 0 && ram_addr[10]) init_phase <= 1;
          else if (init_phase < 4) init_err <= 1'b1;
          if (ram_addr[10]) open_bank <= '0;
          else open_bank[ram_bank_addr] <= 1'b0;
        end
        CMD_REFRESH: begin
          refresh_seen <= 1'b1;
          // All banks must be idle
          if (open_bank != '0) order_err <= 1'b1;
          if (init_phase == 1 || init_phase == 2) init_phase <= init_phase + 1;
          else if (init_phase < 4) init_err <= 1'b1;
        end
        CMD_LOAD_MODE: begin
          if (init_phase == 3 && ram_addr == MODE_EXPECT) init_phase <= 4;
          else init_err <= 1'b1;
        end
        CMD_ACTIVE: begin
          if (init_phase != 4) init_err <= 1'b1;
          if (open_bank[ram_bank_addr]) order_err <= 1'b1;
          open_bank[ram_bank_addr] <= 1'b1;
          open_row[ram_bank_addr]  <= ram_addr;
        end
        CMD_WRITE, CMD_READ: begin
          if (!open_bank[ram_bank_addr]) order_err <= 1'b1;
          // Auto precharge closes the row
          if (ram_addr[10]) open_bank[ram_bank_addr] <= 1'b0;
          if (cmd == CMD_WRITE) begin
            mem[loc] = ram_data;
          end else begin
            rd_word <= mem.exists(loc) ? mem[loc] : data_t'(loc);
            rd_cnt  <= `SDRAM_CAS_LATENCY - 1;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

// File: dv/sdram_ctrl_chk.sv
// Bound checker for command spacing, data pin drive and clock enable of the command sequencer
`timescale 1ns/1ps
`include "sdram_ctrl_config.svh"

module sdram_ctrl_chk
  import sdram_ctrl_pkg::*;
(
  input logic fpga_clk,
  input logic fpga_reset,
  input logic ram_cs_n,
  input logic ram_ras_n,
  input logic ram_cas_n,
  input logic ram_we_n,
  input logic ram_clk_en,
  input logic data_oe
);

  localparam int unsigned FAR = 1000;

  sdram_cmd_t  cmd;
  // Saturating cycle counts since the last ACTIVE, REFRESH and READ
  int unsigned since_act;
  int unsigned since_ref;
  int unsigned since_rd;
  logic        past_first;
  int          fail_cnt = 0;

  assign cmd = sdram_cmd_t'({ram_cs_n, ram_ras_n, ram_cas_n, ram_we_n});

  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      since_act  <= FAR;
      since_ref  <= FAR;
      since_rd   <= FAR;
      past_first <= 1'b0;
    end else begin
      past_first <= 1'b1;
      if (cmd == CMD_ACTIVE) since_act <= 1;
      else if (since_act < FAR) since_act <= since_act + 1;
      if (cmd == CMD_REFRESH) since_ref <= 1;
      else if (since_ref < FAR) since_ref <= since_ref + 1;
      if (cmd == CMD_READ) since_rd <= 1;
      else if (since_rd < FAR) since_rd <= since_rd + 1;
    end
  end

  // Column access needs the row open for T_RCD
  rcd_spacing: assert property (@(posedge fpga_clk) disable iff (fpga_reset)
    (cmd inside {CMD_READ, CMD_WRITE}) |-> (since_act >= `SDRAM_T_RCD))
    else begin
      $error("READ or WRITE issued sooner than T_RCD after ACTIVE");
      fail_cnt++;
    end

  // Data pins belong to the SDRAM outside the WRITE cycle
  // Read data sits on them CAS latency minus one cycles after the READ cycle
  data_drive: assert property (@(posedge fpga_clk) disable iff (fpga_reset)
    data_oe |-> (cmd == CMD_WRITE) && (since_rd != `SDRAM_CAS_LATENCY - 1))
    else begin
      $error("ram_data driven outside a WRITE command cycle");
      fail_cnt++;
    end

  rc_spacing: assert property (@(posedge fpga_clk) disable iff (fpga_reset)
    !(cmd inside {CMD_NOP, CMD_DESELECT}) |-> (since_ref >= `SDRAM_T_RC))
    else begin
      $error("command issued within T_RC of REFRESH");
      fail_cnt++;
    end

  // Only the first cycle out of reset has the clock disabled
  clk_en_high: assert property (@(posedge fpga_clk) disable iff (fpga_reset)
    past_first |-> ram_clk_en)
    else begin
      $error("ram_clk_en low after the first cycle");
      fail_cnt++;
    end

endmodule

// File: rtl/sdram_ctrl_top.sv
// SDRAM controller top level joining host port, request queue and command sequencer
`timescale 1ns/1ps

module sdram_ctrl_top
  import sdram_ctrl_pkg::*;
(
  input  logic        fpga_clk,
  input  logic        fpga_reset,
  // Host side
  input  logic        host_req,
  output logic        host_ready,
  input  logic        host_write,
  input  host_addr_t  host_addr,
  input  data_t       host_wdata,
  output logic        host_rd_valid,
  output data_t       host_rd_data,
  // SDRAM side
  output sdram_addr_t ram_addr,
  output bank_t       ram_bank_addr,
  output logic        ram_cs_n,
  output logic        ram_ras_n,
  output logic        ram_cas_n,
  output logic        ram_we_n,
  output logic        ram_clk_en,
  inout  data_t       ram_data
);

  // Host port to queue, and queue to sequencer
  sdram_req_if req_in ();
  sdram_req_if req_out ();

  // Read return from sequencer to host port
  logic  seq_rd_valid;
  data_t seq_rd_data;

  sdram_host_port sdram_host_port_i (
    .fpga_clk      (fpga_clk),
    .fpga_reset    (fpga_reset),
    .host_req      (host_req),
    .host_write    (host_write),
    .host_addr     (host_addr),
    .host_wdata    (host_wdata),
    .host_ready    (host_ready),
    .host_rd_valid (host_rd_valid),
    .host_rd_data  (host_rd_data),
    .req_in        (req_in.src),
    .seq_rd_valid  (seq_rd_valid),
    .seq_rd_data   (seq_rd_data)
  );

  sdram_req_fifo sdram_req_fifo_i (
    .fpga_clk   (fpga_clk),
    .fpga_reset (fpga_reset),
    .req_in     (req_in.dst),
    .req_out    (req_out.src)
  );

  sdram_cmd_seq sdram_cmd_seq_i (
    .fpga_clk      (fpga_clk),
    .fpga_reset    (fpga_reset),
    .req_out       (req_out.dst),
    .seq_rd_valid  (seq_rd_valid),
    .seq_rd_data   (seq_rd_data),
    .ram_addr      (ram_addr),
    .ram_bank_addr (ram_bank_addr),
    .ram_cs_n      (ram_cs_n),
    .ram_ras_n     (ram_ras_n),
    .ram_cas_n     (ram_cas_n),
    .ram_we_n      (ram_we_n),
    .ram_clk_en    (ram_clk_en),
    .ram_data      (ram_data)
  );

endmodule

// File: rtl/sdram_cmd_seq.sv
// SDRAM command sequencer with power-up, refresh, activate, read and write control
`timescale 1ns/1ps
`include "sdram_ctrl_config.svh"

module sdram_cmd_seq
  import sdram_ctrl_pkg::*;
(
  input  logic        fpga_clk,
  input  logic        fpga_reset,
  sdram_req_if.dst    req_out,
  output logic        seq_rd_valid,
  output data_t       seq_rd_data,
  output sdram_addr_t ram_addr,
  output bank_t       ram_bank_addr,
  output logic        ram_cs_n,
  output logic        ram_ras_n,
  output logic        ram_cas_n,
  output logic        ram_we_n,
  output logic        ram_clk_en,
  inout  data_t       ram_data
);

  // Wide enough for the longest wait
  localparam int unsigned WAIT_MAX = `SDRAM_INIT_CYCLES + `SDRAM_T_RC + `SDRAM_T_MRD +
    `SDRAM_T_RCD + `SDRAM_T_WR + `SDRAM_T_RP + `SDRAM_CAS_LATENCY;
  localparam int unsigned WAIT_W = $clog2(WAIT_MAX + 1);
  localparam int unsigned REF_W  = $clog2(`SDRAM_REFRESH_INTERVAL + 1);
  localparam int unsigned CL     = `SDRAM_CAS_LATENCY;

  typedef logic [WAIT_W-1:0] wait_t;
  typedef logic [REF_W-1:0]  ref_cnt_t;

  // Counter loads, one less than the spacing since the command edge counts
  localparam wait_t INIT_WAIT  = wait_t'(`SDRAM_INIT_CYCLES - 1);
  localparam wait_t RP_WAIT    = wait_t'(`SDRAM_T_RP - 1);
  localparam wait_t RC_WAIT    = wait_t'(`SDRAM_T_RC - 1);
  localparam wait_t MRD_WAIT   = wait_t'(`SDRAM_T_MRD - 1);
  localparam wait_t RCD_WAIT   = wait_t'(`SDRAM_T_RCD - 1);
  localparam wait_t WRITE_WAIT = wait_t'(`SDRAM_T_WR + `SDRAM_T_RP - 1);
  localparam wait_t READ_WAIT  = wait_t'(`SDRAM_CAS_LATENCY + `SDRAM_T_RP - 1);

  localparam ref_cnt_t    REF_LIMIT      = ref_cnt_t'(`SDRAM_REFRESH_INTERVAL);
  // Address bit 10 selects auto precharge or all banks
  localparam sdram_addr_t AUTO_PRECHARGE = sdram_addr_t'(12'h400);

  seq_state_t     state;
  wait_t          wait_cnt;
  logic [1:0]     init_step;
  sdram_cmd_t     cmd_q;
  ref_cnt_t       refresh_cnt;
  logic           data_oe;
  logic [CL-1:0]  rd_pipe;

  // Request latched at the pop
  logic  req_write;
  bank_t req_bank;
  col_t  req_col;
  data_t req_wdata;

  logic wait_done;
  logic dispatch;
  logic refresh_pending;
  logic pop;

  assign wait_done       = (wait_cnt == '0);
  assign refresh_pending = (refresh_cnt == REF_LIMIT);

  // Free to start new work, in IDLE or at the end of a finished wait
  assign dispatch = (state == ST_IDLE) ||
                    ((state inside {ST_MODE, ST_REFRESH, ST_READ, ST_WRITE}) && wait_done);

  // Refresh wins over the queue
  assign pop           = dispatch && !refresh_pending && req_out.valid;
  assign req_out.ready = pop;

  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      state         <= ST_INIT;
      wait_cnt      <= INIT_WAIT;
      init_step     <= 2'd0;
      cmd_q         <= CMD_DESELECT;
      ram_addr      <= '0;
      ram_bank_addr <= '0;
      ram_clk_en    <= 1'b0;
      refresh_cnt   <= '0;
      data_oe       <= 1'b0;
      rd_pipe       <= '0;
      seq_rd_valid  <= 1'b0;
    end else begin
      // Defaults, NOP on the pins and counters running
      cmd_q        <= CMD_NOP;
      ram_clk_en   <= 1'b1;
      data_oe      <= 1'b0;
      rd_pipe      <= rd_pipe << 1;
      seq_rd_valid <= rd_pipe[CL-1];
      if (refresh_cnt != REF_LIMIT) begin
        refresh_cnt <= refresh_cnt + 1'b1;
      end
      if (!wait_done) begin
        wait_cnt <= wait_cnt - 1'b1;
      end

      case (state)
        ST_INIT: begin
          if (!wait_done) begin
            // Deselect only during the power-up wait
            if (init_step == 2'd0) begin
              cmd_q <= CMD_DESELECT;
            end
          end else begin
            case (init_step)
              2'd0: begin
                cmd_q     <= CMD_PRECHARGE;
                ram_addr  <= AUTO_PRECHARGE;
                wait_cnt  <= RP_WAIT;
                init_step <= 2'd1;
              end
              2'd1, 2'd2: begin
                cmd_q     <= CMD_REFRESH;
                wait_cnt  <= RC_WAIT;
                init_step <= init_step + 1'b1;
              end
              default: begin
                cmd_q    <= CMD_LOAD_MODE;
                ram_addr <= MODE_REG_VALUE;
                wait_cnt <= MRD_WAIT;
                state    <= ST_MODE;
              end
            endcase
          end
        end

        ST_ACTIVATE: begin
          // Row is open, column access with auto precharge
          if (wait_done) begin
            ram_addr      <= AUTO_PRECHARGE | sdram_addr_t'(req_col);
            ram_bank_addr <= req_bank;
            if (req_write) begin
              cmd_q    <= CMD_WRITE;
              data_oe  <= 1'b1;
              wait_cnt <= WRITE_WAIT;
              state    <= ST_WRITE;
            end else begin
              cmd_q      <= CMD_READ;
              rd_pipe[0] <= 1'b1;
              wait_cnt   <= READ_WAIT;
              state      <= ST_READ;
            end
          end
        end

        default: begin
          if (dispatch) begin
            if (refresh_pending) begin
              cmd_q       <= CMD_REFRESH;
              refresh_cnt <= '0;
              wait_cnt    <= RC_WAIT;
              state       <= ST_REFRESH;
            end else if (req_out.valid) begin
              // Open the row of the popped request
              cmd_q         <= CMD_ACTIVE;
              ram_addr      <= sdram_addr_t'(req_out.row);
              ram_bank_addr <= req_out.bank;
              wait_cnt      <= RCD_WAIT;
              state         <= ST_ACTIVATE;
            end else begin
              state <= ST_IDLE;
            end
          end
        end
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge fpga_clk) begin
    if (pop) begin
      req_write <= req_out.write;
      req_bank  <= req_out.bank;
      req_col   <= req_out.col;
      req_wdata <= req_out.wdata;
    end
    // Marker reaches the last stage at the CAS latency edge
    if (rd_pipe[CL-1]) begin
      seq_rd_data <= ram_data;
    end
  end

  assign {ram_cs_n, ram_ras_n, ram_cas_n, ram_we_n} = cmd_q;

  // Data pins driven only in the WRITE command cycle
  assign ram_data = data_oe ? req_wdata : {`SDRAM_DATA_W{1'bz}};

endmodule

// File: rtl/sdram_req_fifo.sv
// Circular request queue between host port and command sequencer
`timescale 1ns/1ps
`include "sdram_ctrl_config.svh"

module sdram_req_fifo
  import sdram_ctrl_pkg::*;
(
  input  logic     fpga_clk,
  input  logic     fpga_reset,
  sdram_req_if.dst req_in,
  sdram_req_if.src req_out
);

  localparam int unsigned DEPTH   = `SDRAM_REQ_DEPTH;
  localparam int unsigned PTR_W   = $clog2(DEPTH);
  localparam int unsigned CNT_W   = $clog2(DEPTH + 1);
  // One entry is {write, bank, row, col, wdata}
  localparam int unsigned ENTRY_W =
    1 + $bits(bank_t) + $bits(row_t) + $bits(col_t) + $bits(data_t);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  logic [ENTRY_W-1:0] mem [DEPTH];
  ptr_t               wr_ptr;
  ptr_t               rd_ptr;
  cnt_t               count;

  logic push;
  logic pop;

  // Full queue stalls the host port
  assign req_in.ready  = (count != cnt_t'(DEPTH));
  assign req_out.valid = (count != '0);

  assign push = req_in.valid && req_in.ready;
  assign pop  = req_out.valid && req_out.ready;

  // Storage
  always_ff @(posedge fpga_clk) begin
    if (push) begin
      mem[wr_ptr] <= {req_in.write, req_in.bank, req_in.row, req_in.col, req_in.wdata};
    end
  end

  // Oldest entry faces the sequencer
  assign {req_out.write, req_out.bank, req_out.row, req_out.col, req_out.wdata} = mem[rd_ptr];

  // Pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy only moves when one side acts alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: rtl/sdram_host_port.sv
// Host request holding register, address split and read return register
`timescale 1ns/1ps

module sdram_host_port
  import sdram_ctrl_pkg::*;
(
  input  logic       fpga_clk,
  input  logic       fpga_reset,
  input  logic       host_req,
  input  logic       host_write,
  input  host_addr_t host_addr,
  input  data_t      host_wdata,
  output logic       host_ready,
  output logic       host_rd_valid,
  output data_t      host_rd_data,
  sdram_req_if.src   req_in,
  input  logic       seq_rd_valid,
  input  data_t      seq_rd_data
);

  // Holding register for one accepted request
  logic       hold_valid;
  logic       hold_write;
  host_addr_t hold_addr;
  data_t      hold_wdata;

  logic accept;
  logic drain;

  // Register is free, or the queue takes its content this cycle
  assign drain      = hold_valid && req_in.ready;
  assign host_ready = !hold_valid || req_in.ready;
  assign accept     = host_req && host_ready;

  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      hold_valid <= 1'b0;
    end else if (accept) begin
      hold_valid <= 1'b1;
    end else if (drain) begin
      hold_valid <= 1'b0;
    end
  end

  always_ff @(posedge fpga_clk) begin
    if (accept) begin
      hold_write <= host_write;
      hold_addr  <= host_addr;
      hold_wdata <= host_wdata;
    end
  end

  // Offer to the queue, address split as {bank, row, col}
  assign req_in.valid = hold_valid;
  assign req_in.write = hold_write;
  assign req_in.wdata = hold_wdata;
  assign {req_in.bank, req_in.row, req_in.col} = hold_addr;

  // Read return is registered once toward the host
  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      host_rd_valid <= 1'b0;
    end else begin
      host_rd_valid <= seq_rd_valid;
    end
  end

  always_ff @(posedge fpga_clk) begin
    if (seq_rd_valid) begin
      host_rd_data <= seq_rd_data;
    end
  end

endmodule

// File: rtl/sdram_req_if.sv
// Request channel carrying one SDRAM access between host port, queue and sequencer
`timescale 1ns/1ps

interface sdram_req_if
  import sdram_ctrl_pkg::*;
();

  // Handshake, an item moves when both are high on an edge
  logic  valid;
  logic  ready;

  // Request payload
  logic  write;
  bank_t bank;
  row_t  row;
  col_t  col;
  data_t wdata;

  // Side that offers requests
  modport src (output valid, write, bank, row, col, wdata, input ready);

  // Side that takes requests
  modport dst (input valid, write, bank, row, col, wdata, output ready);

endinterface

// File: rtl/sdram_ctrl_pkg.sv
// Address, data, SDRAM command and sequencer state types with the mode register value
`include "sdram_ctrl_config.svh"

package sdram_ctrl_pkg;

  // Host address fields
  typedef logic [`SDRAM_BANK_W-1:0] bank_t;
  typedef logic [`SDRAM_ROW_W-1:0]  row_t;
  typedef logic [`SDRAM_COL_W-1:0]  col_t;

  // Host address is {bank, row, col}
  typedef logic [`SDRAM_BANK_W+`SDRAM_ROW_W+`SDRAM_COL_W-1:0] host_addr_t;

  typedef logic [`SDRAM_DATA_W-1:0] data_t;

  // SDRAM address bus is as wide as a row
  typedef logic [`SDRAM_ROW_W-1:0] sdram_addr_t;

  // Pin codes {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_DESELECT  = 4'b1111,
    CMD_NOP       = 4'b0111,
    CMD_READ      = 4'b0101,
    CMD_WRITE     = 4'b0100,
    CMD_ACTIVE    = 4'b0011,
    CMD_PRECHARGE = 4'b0010,
    CMD_REFRESH   = 4'b0001,
    CMD_LOAD_MODE = 4'b0000
  } sdram_cmd_t;

  // Command sequencer states
  typedef enum logic [2:0] {
    ST_INIT,
    ST_MODE,
    ST_IDLE,
    ST_REFRESH,
    ST_ACTIVATE,
    ST_READ,
    ST_WRITE
  } seq_state_t;

  // Single location writes, CAS latency, sequential, burst length 1
  localparam sdram_addr_t MODE_REG_VALUE =
    {2'b00, 1'b1, 2'b00, 3'(`SDRAM_CAS_LATENCY), 1'b0, 3'b000};

endpackage

// File: rtl/sdram_ctrl_config.svh
// Timing cycle counts, queue depth, CAS latency and bus widths of the SDRAM controller
`ifndef SDRAM_CTRL_CONFIG_SVH
`define SDRAM_CTRL_CONFIG_SVH

// Deselect cycles after reset before the first precharge
// Kept short so simulation reaches traffic quickly
`define SDRAM_INIT_CYCLES 20

// Command spacing in clock cycles, counted from the command edge
`define SDRAM_T_RP  2
`define SDRAM_T_RC  4
`define SDRAM_T_MRD 2
`define SDRAM_T_RCD 2
`define SDRAM_T_WR  2

// Read data arrives this many edges after the READ command
`define SDRAM_CAS_LATENCY 2

// Cycles between refresh requests
`define SDRAM_REFRESH_INTERVAL 120

// Number of host requests the queue can hold
`define SDRAM_REQ_DEPTH 4

// Address split and data width
`define SDRAM_BANK_W 2
`define SDRAM_ROW_W  12
`define SDRAM_COL_W  9
`define SDRAM_DATA_W 32

`endif
